/* Makefile */
VERILATOR ?= verilator
TOP       ?= aluTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# Build, run, then decide the verdict from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/aluApbRegs.sv */
// APB register block
`default_nettype none

module aluApbRegs (
  input  logic              clk,
  input  logic              rst,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  aluPkg::apbAddr_t  paddr,
  input  aluPkg::word_t     pwdata,
  input  logic              full,      // Queue cannot take a push
  input  logic              notEmpty,  // Commands still waiting
  input  logic              aluIdle,
  input  logic              resValid,  // One-cycle result strobe
  input  aluPkg::word_t     result,
  output aluPkg::word_t     prdata,
  output logic              pready,
  output logic              pslverr,
  output logic              push,
  output aluPkg::cmd_t      pushCmd
);

  aluPkg::word_t opA;          // Operand A register
  aluPkg::word_t opB;          // Operand B register
  aluPkg::word_t resultReg;    // Last completed result
  logic [15:0]   doneCount;    // Completed commands, wraps
  logic          access;       // Second APB phase
  logic          wrCtrl;       // CTRL write in this cycle
  logic          ctrlRejected; // CTRL write hit a full queue
  logic          addrKnown;    // Offset decodes to a register
  logic          busy;

  assign access       = psel && penable;
  assign wrCtrl       = access && pwrite && (paddr == aluPkg::REG_CTRL);
  assign ctrlRejected = wrCtrl && full;
  assign push         = wrCtrl && !full;  // Pushed in the access cycle
  assign pready       = 1'b1;             // No wait states
  assign busy         = notEmpty || !aluIdle;

  // Command from current operands and CTRL data
  assign pushCmd = {pwdata[3], aluPkg::aluFunc_t'(pwdata[2:0]), opB, opA};

  // Read mux and address decode
  always_comb begin
    addrKnown = 1'b1;
    case (paddr)
      aluPkg::REG_OPA:    prdata = opA;
      aluPkg::REG_OPB:    prdata = opB;
      aluPkg::REG_CTRL:   prdata = '0;  // Write-only
      aluPkg::REG_STATUS: prdata = {doneCount, 14'd0, full, busy};
      aluPkg::REG_RESULT: prdata = resultReg;
      default: begin
        prdata    = '0;
        addrKnown = 1'b0;  // Unmapped offset
      end
    endcase
  end

  assign pslverr = access && (!addrKnown || ctrlRejected);

  // Operand registers
  always_ff @(posedge clk) begin
    if (access && pwrite) begin
      if (paddr == aluPkg::REG_OPA) begin
        opA <= pwdata;
      end
      if (paddr == aluPkg::REG_OPB) begin
        opB <= pwdata;
      end
    end
  end

  // Result capture and completion counter
  always_ff @(posedge clk) begin
    if (rst) begin
      resultReg <= '0;
      doneCount <= '0;
    end else if (resValid) begin
      resultReg <= result;
      doneCount <= doneCount + 16'd1;  // Modulo 65536
    end
  end

endmodule

`default_nettype wire

/* hw/aluCmdQueue.sv */
// ALU command FIFO
`default_nettype none

module aluCmdQueue #(
  parameter int QUEUE_DEPTH = 4  // Power of two
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         push,
  input  aluPkg::cmd_t pushCmd,
  input  logic         pop,
  output aluPkg::cmd_t headCmd,   // Oldest entry, fall-through
  output logic         notEmpty,
  output logic         full
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = PTR_W + 1;  // Holds 0..QUEUE_DEPTH
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(QUEUE_DEPTH);

  aluPkg::cmd_t     mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;  // Occupancy

  assign headCmd  = mem[rdPtr];
  assign notEmpty = (count != '0);
  assign full     = (count == FULL_CNT);

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= pushCmd;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or push with pop
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/aluPkg.sv */
// ALU coprocessor shared definitions
`default_nettype none

package aluPkg;

  typedef logic [31:0] word_t;     // Operands, results, APB data
  typedef logic [2:0]  aluFunc_t;  // RV32I funct3
  typedef logic [4:0]  shamt_t;    // Shift distance from operand B
  typedef logic [67:0] cmd_t;      // {qual, func, opB, opA}
  typedef logic [4:0]  apbAddr_t;  // APB byte address

  // funct3 codes
  localparam aluFunc_t FUNC_ADD  = 3'd0;  // Also sub with qualifier
  localparam aluFunc_t FUNC_SLL  = 3'd1;
  localparam aluFunc_t FUNC_SLT  = 3'd2;
  localparam aluFunc_t FUNC_SLTU = 3'd3;
  localparam aluFunc_t FUNC_XOR  = 3'd4;
  localparam aluFunc_t FUNC_SR   = 3'd5;  // srl, or sra with qualifier
  localparam aluFunc_t FUNC_OR   = 3'd6;
  localparam aluFunc_t FUNC_AND  = 3'd7;

  // Register map
  localparam apbAddr_t REG_OPA    = 5'h00;
  localparam apbAddr_t REG_OPB    = 5'h04;
  localparam apbAddr_t REG_CTRL   = 5'h08;  // Write starts a command
  localparam apbAddr_t REG_STATUS = 5'h0C;
  localparam apbAddr_t REG_RESULT = 5'h10;

  typedef enum logic [1:0] {IDLE, SHIFT, DONE} aluState_e;

endpackage

`default_nettype wire

/* hw/aluTop.sv */
// ALU coprocessor top level
`default_nettype none

module aluTop #(
  parameter int QUEUE_DEPTH     = 4,    // Power of two
  parameter bit TWO_STAGE_SHIFT = 1'b0
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  aluPkg::apbAddr_t paddr,
  input  aluPkg::word_t    pwdata,
  output aluPkg::word_t    prdata,
  output logic             pready,
  output logic             pslverr
);

  logic          push;
  aluPkg::cmd_t  pushCmd;
  logic          full;
  logic          notEmpty;
  aluPkg::cmd_t  headCmd;
  logic          pop;
  logic          aluIdle;
  logic          resValid;
  aluPkg::word_t result;

  // Producer
  aluApbRegs uRegs (
    .clk      (clk),
    .rst      (rst),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .full     (full),
    .notEmpty (notEmpty),
    .aluIdle  (aluIdle),
    .resValid (resValid),
    .result   (result),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .push     (push),
    .pushCmd  (pushCmd)
  );

  // Buffer
  aluCmdQueue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) uQueue (
    .clk      (clk),
    .rst      (rst),
    .push     (push),
    .pushCmd  (pushCmd),
    .pop      (pop),
    .headCmd  (headCmd),
    .notEmpty (notEmpty),
    .full     (full)
  );

  // Consumer
  serialAlu #(
    .TWO_STAGE_SHIFT (TWO_STAGE_SHIFT)
  ) uAlu (
    .clk      (clk),
    .rst      (rst),
    .notEmpty (notEmpty),
    .headCmd  (headCmd),
    .pop      (pop),
    .aluIdle  (aluIdle),
    .resValid (resValid),
    .result   (result)
  );

endmodule

`default_nettype wire

/* hw/serialAlu.sv */
// Sequential RV32I ALU
`default_nettype none

module serialAlu #(
  parameter bit TWO_STAGE_SHIFT = 1'b0  // Four-bit shift steps
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          notEmpty,
  input  aluPkg::cmd_t  headCmd,
  output logic          pop,
  output logic          aluIdle,
  output logic          resValid,
  output aluPkg::word_t result
);

  aluPkg::aluState_e state;
  aluPkg::word_t     workReg;   // Result or value in flight
  aluPkg::shamt_t    shamtCnt;  // Shift distance left
  aluPkg::aluFunc_t  curFunc;
  logic              curQual;
  logic              cmdQual;
  aluPkg::aluFunc_t  cmdFunc;
  aluPkg::word_t     cmdB;
  aluPkg::word_t     cmdA;
  logic              cmdIsShift;
  logic [32:0]       minus;     // A - B with borrow
  logic              lt;
  logic              ltu;
  aluPkg::word_t     aluOut;
  aluPkg::word_t     stepIn;
  aluPkg::word_t     stepOut;
  aluPkg::shamt_t    stepCnt;
  aluPkg::shamt_t    cntNext;
  logic              stepLeft;
  logic              stepArith;
  logic              bigStep;

  assign {cmdQual, cmdFunc, cmdB, cmdA} = headCmd;

  assign aluIdle  = (state == aluPkg::IDLE);
  assign pop      = aluIdle && notEmpty;
  assign resValid = (state == aluPkg::DONE);
  assign result   = workReg;

  assign cmdIsShift = (cmdFunc == aluPkg::FUNC_SLL) || (cmdFunc == aluPkg::FUNC_SR);

  // One subtraction serves sub, slt and sltu
  assign minus = {1'b0, cmdA} - {1'b0, cmdB};
  assign ltu   = minus[32];
  assign lt    = (cmdA[31] ^ cmdB[31]) ? cmdA[31] : minus[32];  // Signs differ

  always_comb begin
    case (cmdFunc)
      aluPkg::FUNC_ADD:  aluOut = cmdQual ? minus[31:0] : cmdA + cmdB;
      aluPkg::FUNC_SLT:  aluOut = {31'd0, lt};
      aluPkg::FUNC_SLTU: aluOut = {31'd0, ltu};
      aluPkg::FUNC_XOR:  aluOut = cmdA ^ cmdB;
      aluPkg::FUNC_OR:   aluOut = cmdA | cmdB;
      aluPkg::FUNC_AND:  aluOut = cmdA & cmdB;
      default:           aluOut = cmdA;  // Shifts take the shifter path
    endcase
  end

  // Shifter step, first step comes straight from the queue head
  assign stepIn    = aluIdle ? cmdA : workReg;
  assign stepCnt   = aluIdle ? cmdB[4:0] : shamtCnt;  // Low 5 bits of B only
  assign stepLeft  = aluIdle ? (cmdFunc == aluPkg::FUNC_SLL) : (curFunc == aluPkg::FUNC_SLL);
  assign stepArith = aluIdle ? cmdQual : curQual;
  assign bigStep   = TWO_STAGE_SHIFT && (stepCnt > 5'd4);
  assign cntNext   = stepCnt - (bigStep ? 5'd4 : 5'd1);

  always_comb begin
    if (bigStep) begin
      stepOut = stepLeft ? {stepIn[27:0], 4'd0} : {{4{stepArith & stepIn[31]}}, stepIn[31:4]};
    end else begin
      stepOut = stepLeft ? {stepIn[30:0], 1'b0} : {stepArith & stepIn[31], stepIn[31:1]};
    end
  end

  // FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= aluPkg::IDLE;
      shamtCnt <= '0;
    end else begin
      case (state)
        aluPkg::IDLE: begin
          if (notEmpty) begin
            shamtCnt <= cntNext;
            if (!cmdIsShift || stepCnt == '0 || cntNext == '0) begin
              state <= aluPkg::DONE;  // Done within the pop cycle
            end else begin
              state <= aluPkg::SHIFT;
            end
          end
        end
        aluPkg::SHIFT: begin
          shamtCnt <= cntNext;
          if (cntNext == '0) begin
            state <= aluPkg::DONE;  // Last step taken
          end
        end
        default: state <= aluPkg::IDLE;  // DONE lasts one cycle
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (pop) begin
      curFunc <= cmdFunc;
      curQual <= cmdQual;
      if (!cmdIsShift) begin
        workReg <= aluOut;
      end else if (stepCnt == '0) begin
        workReg <= cmdA;  // Shift by zero
      end else begin
        workReg <= stepOut;
      end
    end else if (state == aluPkg::SHIFT) begin
      workReg <= stepOut;
    end
  end

endmodule

`default_nettype wire

/* testbench/aluTb.sv */
// ALU coprocessor testbench
`default_nettype none

module aluTb;

  localparam int PERIOD         = 4;
  localparam int QUEUE_DEPTH    = 4;   // aluTop default
  localparam int N_RANDOM       = 4;   // Operand sets per arithmetic op
  localparam int NUM_CMDS       = 5 * N_RANDOM + 6 + 15 + QUEUE_DEPTH + 2;
  localparam int CYCLES_PER_CMD = 40;  // Worst shift plus APB traffic

  logic             clk;
  logic             rst;
  logic             psel;
  logic             penable;
  logic             pwrite;
  aluPkg::apbAddr_t paddr;
  aluPkg::word_t    pwdata;
  aluPkg::word_t    prdata;
  logic             pready;
  logic             pslverr;

  aluTop u_dut (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Compare a response with its expected value
  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // One APB transfer with setup and access phase
  task automatic busTransfer(input logic write, input aluPkg::apbAddr_t addr,
                             input aluPkg::word_t data, output aluPkg::word_t rdata,
                             output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);  // Access phase outputs settled
    rdata = prdata;
    err   = pslverr;
    checkEq("pready", 32'(pready), 32'd1);
    @(posedge clk);  // Access completes here
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic writeReg(input aluPkg::apbAddr_t addr, input aluPkg::word_t data,
                          output logic err);
    aluPkg::word_t unused;
    busTransfer(1'b1, addr, data, unused, err);
  endtask

  task automatic readReg(input aluPkg::apbAddr_t addr, output aluPkg::word_t data,
                         output logic err);
    busTransfer(1'b0, addr, 32'd0, data, err);
  endtask

  // Poll STATUS busy until clear
  task automatic waitIdle();
    aluPkg::word_t status;
    logic          err;
    status = 32'd1;
    while (status[0]) begin
      readReg(aluPkg::REG_STATUS, status, err);
    end
  endtask

  // RV32I reference results
  function automatic aluPkg::word_t expectedResult(input logic qual, input aluPkg::aluFunc_t func,
                                                   input aluPkg::word_t a,
                                                   input aluPkg::word_t b);
    logic [4:0] sh;
    sh = b[4:0];  // Only the low 5 bits count
    case (func)
      aluPkg::FUNC_ADD:  return qual ? a - b : a + b;
      aluPkg::FUNC_SLL:  return a << sh;
      aluPkg::FUNC_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      aluPkg::FUNC_SLTU: return (a < b) ? 32'd1 : 32'd0;
      aluPkg::FUNC_XOR:  return a ^ b;
      aluPkg::FUNC_SR:   return qual ? aluPkg::word_t'($signed(a) >>> sh) : a >> sh;
      aluPkg::FUNC_OR:   return a | b;
      default:           return a & b;
    endcase
  endfunction

  // Load operands, issue, wait, compare
  task automatic runCmd(input logic qual, input aluPkg::aluFunc_t func,
                        input aluPkg::word_t a, input aluPkg::word_t b);
    aluPkg::word_t res;
    logic          err;
    writeReg(aluPkg::REG_OPA, a, err);
    writeReg(aluPkg::REG_OPB, b, err);
    writeReg(aluPkg::REG_CTRL, {28'd0, qual, func}, err);
    checkEq("pslverr on CTRL", 32'(err), 32'd0);  // Queue empty here
    waitIdle();
    readReg(aluPkg::REG_RESULT, res, err);
    checkEq("RESULT", res, expectedResult(qual, func, a, b));
  endtask

  task automatic arithLogicTest();
    aluPkg::word_t a;
    aluPkg::word_t b;
    repeat (N_RANDOM) begin
      a = $urandom();
      b = $urandom();
      runCmd(1'b0, aluPkg::FUNC_ADD, a, b);
      runCmd(1'b1, aluPkg::FUNC_ADD, a, b);  // sub
      runCmd(1'b0, aluPkg::FUNC_XOR, a, b);
      runCmd(1'b0, aluPkg::FUNC_OR, a, b);
      runCmd(1'b0, aluPkg::FUNC_AND, a, b);
    end
  endtask

  // Sign boundary pairs
  task automatic compareTest();
    aluPkg::word_t pairA [3] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h1234_5678};
    aluPkg::word_t pairB [3] = '{32'h0000_0001, 32'h0000_0000, 32'h1234_5678};
    for (int i = 0; i < 3; i++) begin
      runCmd(1'b0, aluPkg::FUNC_SLT, pairA[i], pairB[i]);
      runCmd(1'b0, aluPkg::FUNC_SLTU, pairA[i], pairB[i]);
    end
  endtask

  task automatic shiftTest();
    logic [4:0]    amounts [5] = '{5'd0, 5'd1, 5'd4, 5'd5, 5'd31};
    aluPkg::word_t val;
    aluPkg::word_t hi;
    aluPkg::word_t b;
    for (int i = 0; i < 5; i++) begin
      val = $urandom();
      hi  = $urandom();
      b   = {hi[31:5], amounts[i]};  // Junk above the shift amount
      runCmd(1'b0, aluPkg::FUNC_SLL, val, b);
      runCmd(1'b0, aluPkg::FUNC_SR, val, b);
      runCmd(1'b1, aluPkg::FUNC_SR, val | 32'h8000_0000, b);  // Negative sra
    end
  endtask

  // Slow shifts let the queue fill up
  task automatic queueFullTest();
    aluPkg::word_t status;
    aluPkg::word_t res;
    aluPkg::word_t a;
    logic          err;
    logic          sawFull;
    logic          lastQual;  // Qualifier of the newest accepted command
    int            accepted;
    logic [15:0]   startCount;
    waitIdle();
    readReg(aluPkg::REG_STATUS, status, err);
    startCount = status[31:16];
    a = $urandom() | 32'h8000_0000;  // Negative so srl and sra differ
    writeReg(aluPkg::REG_OPA, a, err);
    writeReg(aluPkg::REG_OPB, 32'd31, err);  // Longest single-step shift
    accepted = 0;
    sawFull  = 1'b0;
    lastQual = 1'b0;
    for (int i = 0; i < QUEUE_DEPTH + 2; i++) begin
      writeReg(aluPkg::REG_CTRL, {28'd0, i[0], aluPkg::FUNC_SR}, err);  // srl and sra in turn
      if (err) begin
        sawFull = 1'b1;
      end else begin
        accepted++;
        lastQual = i[0];
      end
    end
    checkEq("pslverr on full queue", 32'(sawFull), 32'd1);
    readReg(aluPkg::REG_STATUS, status, err);
    checkEq("STATUS busy/full", 32'(status[1:0]), 32'd3);  // ALU still on the first shift
    waitIdle();
    readReg(aluPkg::REG_STATUS, status, err);
    checkEq("STATUS done count", 32'(status[31:16]), 32'(startCount + 16'(accepted)));
    readReg(aluPkg::REG_RESULT, res, err);
    checkEq("RESULT", res, expectedResult(lastQual, aluPkg::FUNC_SR, a, 32'd31));
  endtask

  task automatic statusErrorTest(input logic fresh);
    aluPkg::word_t data;
    logic          err;
    readReg(aluPkg::REG_STATUS, data, err);
    checkEq("STATUS busy/full", 32'(data[1:0]), 32'd0);
    checkEq("pslverr on STATUS", 32'(err), 32'd0);
    if (fresh) begin
      checkEq("STATUS done count", 32'(data[31:16]), 32'd0);  // Reset values
      readReg(aluPkg::REG_RESULT, data, err);
      checkEq("RESULT", data, 32'd0);
    end
    readReg(5'h14, data, err);  // Past the register map
    checkEq("prdata unmapped", data, 32'd0);
    checkEq("pslverr unmapped", 32'(err), 32'd1);
    readReg(5'h1C, data, err);
    checkEq("prdata unmapped", data, 32'd0);
    checkEq("pslverr unmapped", 32'(err), 32'd1);
  endtask

  // Watchdog
  initial begin
    #(NUM_CMDS * CYCLES_PER_CMD * PERIOD);
    $display("Timeout: tests did not finish within %0d cycles", NUM_CMDS * CYCLES_PER_CMD);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

  // Bound checker failures end the run at once
  initial begin
    wait (u_dut.uProps.failCount != 0);
    $display("Assertion failure in the bound checker at t=%0t", $time);
    $display("SIMULATION FAILED");
    $fatal(1, "assertion failed");
  end

  initial begin
    void'($urandom(32'h9dd6dede));
    rst     = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    statusErrorTest(1'b1);
    arithLogicTest();
    compareTest();
    shiftTest();
    queueFullTest();
    statusErrorTest(1'b0);  // Drained again
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/aluTb_properties.sv */
// ALU coprocessor assertions
`default_nettype none

module aluTbProperties (
  input logic clk,
  input logic rst,
  input logic push,
  input logic full,
  input logic pop,
  input logic notEmpty,
  input logic psel,
  input logic penable,
  input logic pslverr,
  input logic resValid
);

  int failCount = 0;  // Assertion failures so far

  // Register block honors back-pressure
  pushNotFull: assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else begin
      failCount++;
      $error("push while the queue is full");
    end

  popNotEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> notEmpty)
    else begin
      failCount++;
      $error("pop from an empty queue");  // ALU reads only valid heads
    end

  errInAccess: assert property (@(posedge clk) disable iff (rst) pslverr |-> (psel && penable))
    else begin
      failCount++;
      $error("pslverr outside an access cycle");
    end

  // DONE lasts a single cycle
  validOneCycle: assert property (@(posedge clk) disable iff (rst) resValid |=> !resValid)
    else begin
      failCount++;
      $error("resValid high in two cycles in a row");
    end

endmodule

bind aluTop aluTbProperties uProps (
  .clk      (clk),
  .rst      (rst),
  .push     (push),
  .full     (full),
  .pop      (pop),
  .notEmpty (notEmpty),
  .psel     (psel),
  .penable  (penable),
  .pslverr  (pslverr),
  .resValid (resValid)
);

`default_nettype wire

/* vlog.f */
hw/aluPkg.sv
hw/aluApbRegs.sv
hw/aluCmdQueue.sv
hw/serialAlu.sv
hw/aluTop.sv
testbench/aluTb_properties.sv
testbench/aluTb.sv
